// File: tsu_pkg.sv
`default_nettype none

package tsu_pkg;

	// video line or x pixel coordinate, 512 positions
	typedef logic [8:0] line_t;

	// DRAM page, the top bits of a DRAM word address
	typedef logic [7:0] page_t;

	// data word of DRAM and of both local memories
	typedef logic [15:0] word_t;

	// sprite file address, 85 descriptors of three words
	typedef logic [7:0] sf_addr_t;

	// tile map buffer address
	// slot[8:7], word in row[6:1], plane[0]
	typedef logic [8:0] tmb_addr_t;

	// DRAM word address
	typedef logic [20:0] dram_addr_t;

	// tile number, bits 11:6 give the bitmap row, 5:0 the column
	typedef logic [11:0] tile_num_t;

	// renderer palette
	typedef logic [3:0] pal_t;

	// graphics word within a bitmap line
	typedef logic [5:0] tsr_addr_t;

	// size code, 8 to 64 pixels in steps of 8
	typedef logic [2:0] xsize_t;

	// memory depths
	localparam int SF_WORDS = 256;
	localparam int TMB_WORDS = 512;

	// layers in scan order
	localparam int LAYERS = 6;
	localparam int LYR_TM = 0;
	localparam int LYR_S0 = 1;
	localparam int LYR_T0 = 2;
	localparam int LYR_S1 = 3;
	localparam int LYR_T1 = 4;
	localparam int LYR_S2 = 5;

	// sprite file address that ends all sprite layers
	localparam int SF_LAST = 255;

	// the prefetch works this many lines ahead of the render
	localparam int TM_LOOKAHEAD = 16;

	// sprite walker, one state per descriptor word read
	typedef enum logic [2:0] {
		SPR_NONE,
		SPR_R0_PRE,
		SPR_R0,
		SPR_R1_PRE,
		SPR_R1,
		SPR_R2
	} spr_state_e;

	// tile walker, read issued or descriptor on the bus
	typedef enum logic {
		TILE_PRE,
		TILE_VALID
	} tile_state_e;

endpackage

`default_nettype wire

// File: sprite_file.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_file import tsu_pkg::*; (
	input  logic     clk,
	// cpu side
	input  sf_addr_t wr_addr,
	input  word_t    wr_data,
	input  logic     we,
	// walker side
	input  sf_addr_t rd_addr,
	output word_t    rd_data
);

	// 85 descriptors of three words, R0 R1 R2 in a row
	// the top word 255 is never part of a descriptor
	word_t mem [SF_WORDS];

	always_ff @(posedge clk)
	begin
		if (we)
			mem[wr_addr] <= wr_data;
		// one cycle read latency
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: tile_map_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tile_map_buffer import tsu_pkg::*; (
	input  logic      clk,
	// prefetch side
	input  tmb_addr_t wr_addr,
	input  word_t     wr_data,
	input  logic      we,
	// tile walker side
	input  tmb_addr_t rd_addr,
	output word_t     rd_data
);

	// four tile row slots x 64 tiles x two planes
	// plane is the lsb so both planes of a column sit side by side
	word_t mem [TMB_WORDS];

	always_ff @(posedge clk)
	begin
		if (we)
			mem[wr_addr] <= wr_data;
		// registered read, data valid the cycle after the address
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: tile_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tile_fetch import tsu_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	input  line_t      line,
	input  logic       tm_active,
	input  logic       t0_en,
	input  logic       t1_en,
	input  page_t      tmpage,
	input  line_t      t0y_offs,
	input  line_t      t1y_offs,
	input  logic       dram_next,
	output dram_addr_t dram_addr,
	output logic       dram_req,
	output logic       tm_end,
	output tmb_addr_t  tmb_waddr,
	output logic       tmb_we
);

	// tilemap x counter
	// bit 3 selects the plane, bits 2:0 the word in the burst
	logic [4:0] tm_x;
	logic       tm_done;
	line_t      tm_line;
	logic [5:0] tm_row;
	logic       tm_plane;
	logic       tm_last;

	// line being prefetched
	assign tm_line = line + line_t'(TM_LOOKAHEAD);
	assign tm_plane = tm_x[3];

	// tile row in the map, coarse y scroll of the plane added
	assign tm_row = tm_line[8:3] + (tm_plane ? t1y_offs[8:3] : t0y_offs[8:3]);

	// page, row, plane, burst by fine line, word
	// each of the 8 lines of a row fetches its own 8 tiles
	assign dram_addr = {tmpage, tm_row, tm_plane, tm_line[2:0], tm_x[2:0]};

	// slot by row of the prefetched line, then word in row, then plane
	assign tmb_waddr = {tm_line[4:3], tm_line[2:0], tm_x[2:0], tm_plane};

	// T1 words are 8..15, so the run stops at 16 when T1 is on
	assign tm_last = tm_x == (t1_en ? 5'd16 : 5'd8);

	// request drops on the last word
	// a late dram_next then cannot write past the run
	assign dram_req = tm_active && !tm_last;
	assign tmb_we = dram_next && dram_req;

	// single end pulse while the sequencer still shows TM active
	assign tm_end = tm_active && tm_last && !tm_done;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tm_x <= 5'd8;
		else if (start)
			tm_x <= t0_en ? 5'd0 : 5'd8;
		else if (tmb_we)
			tm_x <= tm_x + 5'd1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tm_done <= 1'b0;
		else if (start)
			tm_done <= 1'b0;
		else if (tm_end)
			tm_done <= 1'b1;
	end

endmodule

`default_nettype wire

// File: tile_walker.sv
`timescale 1ns/1ps
`default_nettype none

module tile_walker import tsu_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	input  line_t      line,
	input  logic [1:0] tile_active,
	input  logic       t0_en,
	input  logic [1:0] tsconf_zero,
	input  logic [5:0] num_tiles,
	input  line_t      t0x_offs,
	input  line_t      t1x_offs,
	input  line_t      t0y_offs,
	input  line_t      t1y_offs,
	input  page_t      t0gpage,
	input  page_t      t1gpage,
	input  logic [1:0] t0_palsel,
	input  logic [1:0] t1_palsel,
	input  word_t      tmb_rdata,
	input  logic       tsr_rdy,
	output tmb_addr_t  tmb_raddr,
	output logic       tile_go,
	output logic [1:0] tile_end,
	output line_t      tile_x,
	output line_t      tile_line,
	output tsr_addr_t  tile_addr,
	output page_t      tile_page,
	output pal_t       tile_pal,
	output logic       tile_xf
);

	// one-hot plane, bit 0 is T0, zero once T1 has ended
	logic [1:0]  t_layer;
	tile_state_e state;
	// tile column, one ahead of the descriptor on tmb_rdata
	logic [5:0]  tx;

	logic        t_sel;
	line_t       tx_offs;
	logic [2:0]  ty_offs;
	logic [4:0]  t_line;
	tile_num_t   t_tnum;
	logic [1:0]  t_pal;
	logic        t_yflp;
	logic        in_valid;
	logic        tile_ok;
	logic        tile_good;
	logic        tile_skip;
	logic        tile_wait;
	logic        t_allowed;
	logic        t_layer_end;
	logic        t_layer_start;

	// tile descriptor
	assign t_tnum = tmb_rdata[11:0];
	assign t_pal = tmb_rdata[13:12];
	assign tile_xf = tmb_rdata[14];
	assign t_yflp = tmb_rdata[15];

	// per plane settings
	assign t_sel = t_layer[0];
	assign tx_offs = t_sel ? t0x_offs : t1x_offs;
	assign ty_offs = t_sel ? t0y_offs[2:0] : t1y_offs[2:0];

	// fine y scroll may carry into the next row slot
	assign t_line = line[4:0] + {2'b00, ty_offs};
	assign tmb_raddr = {t_line[4:3], tx + tx_offs[8:3], ~t_sel};

	// zero tile only with its plane's zero enable
	assign tile_ok = (|t_tnum) || (t_sel ? tsconf_zero[0] : tsconf_zero[1]);
	assign in_valid = state == TILE_VALID;
	assign tile_good = in_valid && tile_ok;
	assign tile_skip = in_valid && !tile_ok;

	// go only for the active plane with the renderer free
	assign t_allowed = (|(tile_active & t_layer)) && tsr_rdy;
	assign tile_go = tile_good && t_allowed;
	assign tile_wait = tile_good && !t_allowed;

	// plane done once the last column is taken or skipped
	// num_tiles of 0 walks all 64 columns
	assign t_layer_end = in_valid && !tile_wait && (tx == num_tiles);
	assign tile_end = {2{t_layer_end}} & t_layer;
	assign t_layer_start = start || t_layer_end;

	// renderer task
	assign tile_x = {tx - 6'd1, 3'd0} - {6'd0, tx_offs[2:0]};
	assign tile_line = {t_tnum[11:6], t_line[2:0] ^ {3{t_yflp}}};
	assign tile_addr = t_tnum[5:0];
	assign tile_page = t_sel ? t0gpage : t1gpage;
	assign tile_pal = {t_sel ? t0_palsel : t1_palsel, t_pal};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			t_layer <= 2'b00;
		else if (start)
			t_layer <= t0_en ? 2'b01 : 2'b10;
		else if (t_layer_end)
			t_layer <= {t_layer[0], 1'b0};
	end

	// a stalled tile steps back and is read again
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= TILE_PRE;
		else if (t_layer_start || tile_wait)
			state <= TILE_PRE;
		else
			state <= TILE_VALID;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tx <= 6'd0;
		else if (t_layer_start)
			tx <= 6'd0;
		else if (!in_valid || tile_skip || tile_go)
			tx <= tx + 6'd1;
		else if (tile_wait)
			tx <= tx - 6'd1;
	end

endmodule

`default_nettype wire

// File: sprite_walker.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_walker import tsu_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	input  line_t      line,
	input  logic [2:0] spr_active,
	input  page_t      sgpage,
	input  word_t      sf_rdata,
	input  logic       tsr_rdy,
	output sf_addr_t   sf_raddr,
	output logic       spr_go,
	output logic [2:0] spr_end,
	output line_t      spr_x,
	output line_t      spr_line,
	output tsr_addr_t  spr_addr,
	output xsize_t     spr_xs,
	output logic       spr_xf,
	output pal_t       spr_pal,
	output page_t      spr_page
);

	spr_state_e state;
	// file pointer, always the word being read
	sf_addr_t   sreg;
	// one-hot sprite layer, S0 first
	logic [2:0] s_layer;

	// R0 fields
	line_t      s_ycrd;
	xsize_t     s_ysz;
	logic       s_act;
	logic       s_leap;
	logic       s_yflp;

	line_t      s_dline;
	logic [5:0] s_ymax;
	logic [5:0] s_bmoff;
	logic       s_visible;
	logic       spr_valid;
	logic       in_r0;
	logic       sprites_last;
	logic       s_layer_end;

	// latched from R0 and R1
	logic       leap_r;
	logic [5:0] bmoff_r;

	assign s_ycrd = sf_rdata[8:0];
	assign s_ysz = sf_rdata[11:9];
	assign s_act = sf_rdata[13];
	assign s_leap = sf_rdata[14];
	assign s_yflp = sf_rdata[15];

	// sprite line hit by this video line, wraps mod 512
	assign s_dline = line - s_ycrd;
	assign s_ymax = {s_ysz, 3'b111};
	assign s_visible = s_dline <= {3'b000, s_ymax};
	assign spr_valid = s_visible && s_act;
	assign s_bmoff = s_yflp ? (s_ymax - s_dline[5:0]) : s_dline[5:0];

	assign in_r0 = state == SPR_R0;
	assign sf_raddr = sreg;

	// descriptor bases are multiples of 3, 255 is the first past the end
	assign sprites_last = (state != SPR_NONE) && (sreg == sf_addr_t'(SF_LAST));

	// R2 word on the bus, go for the current layer only
	assign spr_go = (state == SPR_R2) && tsr_rdy && (|(spr_active & s_layer));

	// leap ends the layer at the skip or after the task
	assign s_layer_end = (in_r0 && !spr_valid && s_leap) || (spr_go && leap_r);
	assign spr_end = ({3{s_layer_end}} & s_layer) | {3{sprites_last}};

	// renderer task, tile number and palette straight from R2
	assign spr_line = {sf_rdata[11:6], 3'b000} + {3'b000, bmoff_r};
	assign spr_addr = sf_rdata[5:0];
	assign spr_pal = sf_rdata[15:12];
	assign spr_page = sgpage;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= SPR_NONE;
		else if (start)
			state <= SPR_R0_PRE;
		else if (sprites_last)
			state <= SPR_NONE;
		else
		begin
			case (state)
				SPR_R0_PRE:
					state <= SPR_R0;
				// hidden sprite goes straight to the next descriptor
				SPR_R0:
					state <= spr_valid ? SPR_R1_PRE : SPR_R0_PRE;
				SPR_R1_PRE:
					state <= SPR_R1;
				SPR_R1:
					state <= SPR_R2;
				// hold here until the renderer takes the task
				SPR_R2:
					if (spr_go)
						state <= SPR_R0_PRE;
				default:
					state <= SPR_NONE;
			endcase
		end
	end

	// R0 at base, R1 read in R1_PRE, R2 read from R1 on
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			sreg <= '0;
		else if (start)
			sreg <= '0;
		else if (in_r0)
			sreg <= sreg + (spr_valid ? 8'd1 : 8'd3);
		else if (state == SPR_R1_PRE || spr_go)
			sreg <= sreg + 8'd1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			s_layer <= 3'b000;
		else if (start)
			s_layer <= 3'b001;
		else if (s_layer_end)
			s_layer <= {s_layer[1:0], 1'b0};
	end

	always_ff @(posedge clk)
	begin
		if (in_r0)
		begin
			leap_r <= s_leap;
			bmoff_r <= s_bmoff;
		end
		// R1 holds x position, size and flip
		if (state == SPR_R1)
		begin
			spr_x <= sf_rdata[8:0];
			spr_xs <= sf_rdata[11:9];
			spr_xf <= sf_rdata[15];
		end
	end

endmodule

`default_nettype wire

// File: layer_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module layer_sequencer import tsu_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	input  logic       v_ts,
	input  logic       v_pf,
	input  page_t      tsconf,
	input  logic       tm_end,
	input  logic [1:0] tile_end,
	input  logic [2:0] spr_end,
	// tile task
	input  logic       tile_go,
	input  line_t      tile_x,
	input  line_t      tile_line,
	input  tsr_addr_t  tile_addr,
	input  page_t      tile_page,
	input  pal_t       tile_pal,
	input  logic       tile_xf,
	// sprite task
	input  logic       spr_go,
	input  line_t      spr_x,
	input  line_t      spr_line,
	input  tsr_addr_t  spr_addr,
	input  xsize_t     spr_xs,
	input  logic       spr_xf,
	input  pal_t       spr_pal,
	input  page_t      spr_page,
	output logic       tm_active,
	output logic [1:0] tile_active,
	output logic [2:0] spr_active,
	// renderer
	output logic       tsr_go,
	output tsr_addr_t  tsr_addr,
	output line_t      tsr_line,
	output page_t      tsr_page,
	output line_t      tsr_x,
	output xsize_t     tsr_xs,
	output logic       tsr_xf,
	output pal_t       tsr_pal
);

	// one-hot scan position, walks up over skipped layers
	logic [LAYERS-1:0] layer;
	logic [LAYERS-1:0] layer_active;
	logic [LAYERS-1:0] layer_skip;
	logic [LAYERS-1:0] layer_enabled;
	logic [LAYERS-1:0] layer_allowed;
	logic [LAYERS-1:0] layer_end;
	logic              spr_sel;

	// enables from tsconf, windows from the video timing
	always_comb
	begin
		layer_enabled[LYR_TM] = tsconf[6] || tsconf[5];
		layer_enabled[LYR_S0] = tsconf[7];
		layer_enabled[LYR_T0] = tsconf[5];
		layer_enabled[LYR_S1] = tsconf[7];
		layer_enabled[LYR_T1] = tsconf[6];
		layer_enabled[LYR_S2] = tsconf[7];

		layer_allowed = {LAYERS{v_ts}};
		layer_allowed[LYR_TM] = v_pf;

		layer_end[LYR_TM] = tm_end;
		layer_end[LYR_S0] = spr_end[0];
		layer_end[LYR_T0] = tile_end[0];
		layer_end[LYR_S1] = spr_end[1];
		layer_end[LYR_T1] = tile_end[1];
		layer_end[LYR_S2] = spr_end[2];
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			layer <= '0;
		else if (start)
			layer <= LAYERS'(1);
		else if (|(layer & layer_skip))
			layer <= {layer[LAYERS-2:0], 1'b0};
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			layer_active <= '0;
		else if (start)
			layer_active <= '0;
		else
			layer_active <= layer & ~layer_skip;
	end

	// an end may come early, before its layer is reached
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			layer_skip <= '1;
		else if (start)
			layer_skip <= ~(layer_enabled & layer_allowed);
		else
			layer_skip <= layer_skip | layer_end;
	end

	assign tm_active = layer_active[LYR_TM];
	assign tile_active = {layer_active[LYR_T1], layer_active[LYR_T0]};
	assign spr_active = {layer_active[LYR_S2], layer_active[LYR_S1], layer_active[LYR_S0]};

	// walkers check tsr_rdy and their own layer
	assign spr_sel = |spr_active;
	assign tsr_go = tile_go || spr_go;
	assign tsr_x = spr_sel ? spr_x : tile_x;
	// tiles are always 8 pixels wide
	assign tsr_xs = spr_sel ? spr_xs : 3'd0;
	assign tsr_xf = spr_sel ? spr_xf : tile_xf;
	assign tsr_page = spr_sel ? spr_page : tile_page;
	assign tsr_line = spr_sel ? spr_line : tile_line;
	assign tsr_addr = spr_sel ? spr_addr : tile_addr;
	assign tsr_pal = spr_sel ? spr_pal : tile_pal;

endmodule

`default_nettype wire

// File: video_tsu.sv
`timescale 1ns/1ps
`default_nettype none

module video_tsu import tsu_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	// video timing
	input  logic       start,
	input  line_t      line,
	input  logic       v_ts,
	input  logic       v_pf,
	// configuration
	input  page_t      tsconf,
	input  page_t      t0gpage,
	input  page_t      t1gpage,
	input  page_t      sgpage,
	input  page_t      tmpage,
	input  logic [5:0] num_tiles,
	input  line_t      t0x_offs,
	input  line_t      t1x_offs,
	input  line_t      t0y_offs,
	input  line_t      t1y_offs,
	input  logic [1:0] t0_palsel,
	input  logic [1:0] t1_palsel,
	// sprite file writes
	input  sf_addr_t   sfile_addr,
	input  word_t      sfile_data,
	input  logic       sfile_we,
	// DRAM
	output dram_addr_t dram_addr,
	output logic       dram_req,
	input  logic       dram_next,
	input  word_t      dram_rdata,
	// renderer
	output logic       tsr_go,
	output tsr_addr_t  tsr_addr,
	output line_t      tsr_line,
	output page_t      tsr_page,
	output line_t      tsr_x,
	output xsize_t     tsr_xs,
	output logic       tsr_xf,
	output pal_t       tsr_pal,
	input  logic       tsr_rdy
);

	logic       tm_active;
	logic       tm_end;
	logic [1:0] tile_active;
	logic [1:0] tile_end;
	logic [2:0] spr_active;
	logic [2:0] spr_end;

	tmb_addr_t  tmb_waddr;
	tmb_addr_t  tmb_raddr;
	logic       tmb_we;
	word_t      tmb_rdata;
	sf_addr_t   sf_raddr;
	word_t      sf_rdata;

	// tile task
	logic       tile_go;
	line_t      tile_x;
	line_t      tile_line;
	tsr_addr_t  tile_addr;
	page_t      tile_page;
	pal_t       tile_pal;
	logic       tile_xf;

	// sprite task
	logic       spr_go;
	line_t      spr_x;
	line_t      spr_line;
	tsr_addr_t  spr_addr;
	xsize_t     spr_xs;
	logic       spr_xf;
	pal_t       spr_pal;
	page_t      spr_page;

	sprite_file u_sprite_file (
		.clk     (clk),
		.wr_addr (sfile_addr),
		.wr_data (sfile_data),
		.we      (sfile_we),
		.rd_addr (sf_raddr),
		.rd_data (sf_rdata)
	);

	// tilemap words go from DRAM straight into the buffer
	tile_map_buffer u_tile_map_buffer (
		.clk     (clk),
		.wr_addr (tmb_waddr),
		.wr_data (dram_rdata),
		.we      (tmb_we),
		.rd_addr (tmb_raddr),
		.rd_data (tmb_rdata)
	);

	tile_fetch u_tile_fetch (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.line      (line),
		.tm_active (tm_active),
		.t0_en     (tsconf[5]),
		.t1_en     (tsconf[6]),
		.tmpage    (tmpage),
		.t0y_offs  (t0y_offs),
		.t1y_offs  (t1y_offs),
		.dram_next (dram_next),
		.dram_addr (dram_addr),
		.dram_req  (dram_req),
		.tm_end    (tm_end),
		.tmb_waddr (tmb_waddr),
		.tmb_we    (tmb_we)
	);

	// zero enables, tsconf[2] for T0 and tsconf[3] for T1
	tile_walker u_tile_walker (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.line        (line),
		.tile_active (tile_active),
		.t0_en       (tsconf[5]),
		.tsconf_zero (tsconf[3:2]),
		.num_tiles   (num_tiles),
		.t0x_offs    (t0x_offs),
		.t1x_offs    (t1x_offs),
		.t0y_offs    (t0y_offs),
		.t1y_offs    (t1y_offs),
		.t0gpage     (t0gpage),
		.t1gpage     (t1gpage),
		.t0_palsel   (t0_palsel),
		.t1_palsel   (t1_palsel),
		.tmb_rdata   (tmb_rdata),
		.tsr_rdy     (tsr_rdy),
		.tmb_raddr   (tmb_raddr),
		.tile_go     (tile_go),
		.tile_end    (tile_end),
		.tile_x      (tile_x),
		.tile_line   (tile_line),
		.tile_addr   (tile_addr),
		.tile_page   (tile_page),
		.tile_pal    (tile_pal),
		.tile_xf     (tile_xf)
	);

	sprite_walker u_sprite_walker (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.line       (line),
		.spr_active (spr_active),
		.sgpage     (sgpage),
		.sf_rdata   (sf_rdata),
		.tsr_rdy    (tsr_rdy),
		.sf_raddr   (sf_raddr),
		.spr_go     (spr_go),
		.spr_end    (spr_end),
		.spr_x      (spr_x),
		.spr_line   (spr_line),
		.spr_addr   (spr_addr),
		.spr_xs     (spr_xs),
		.spr_xf     (spr_xf),
		.spr_pal    (spr_pal),
		.spr_page   (spr_page)
	);

	layer_sequencer u_layer_sequencer (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.v_ts        (v_ts),
		.v_pf        (v_pf),
		.tsconf      (tsconf),
		.tm_end      (tm_end),
		.tile_end    (tile_end),
		.spr_end     (spr_end),
		.tile_go     (tile_go),
		.tile_x      (tile_x),
		.tile_line   (tile_line),
		.tile_addr   (tile_addr),
		.tile_page   (tile_page),
		.tile_pal    (tile_pal),
		.tile_xf     (tile_xf),
		.spr_go      (spr_go),
		.spr_x       (spr_x),
		.spr_line    (spr_line),
		.spr_addr    (spr_addr),
		.spr_xs      (spr_xs),
		.spr_xf      (spr_xf),
		.spr_pal     (spr_pal),
		.spr_page    (spr_page),
		.tm_active   (tm_active),
		.tile_active (tile_active),
		.spr_active  (spr_active),
		.tsr_go      (tsr_go),
		.tsr_addr    (tsr_addr),
		.tsr_line    (tsr_line),
		.tsr_page    (tsr_page),
		.tsr_x       (tsr_x),
		.tsr_xs      (tsr_xs),
		.tsr_xf      (tsr_xf),
		.tsr_pal     (tsr_pal)
	);

endmodule

`default_nettype wire

// File: tsu_properties.sv
`timescale 1ns/1ps
`default_nettype none

module tsu_properties (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic v_pf,
	input logic dram_req,
	input logic tsr_go,
	input logic tsr_rdy,
	input logic tile_go,
	input logic spr_go
);

	// prefetch window as seen by the last start
	logic pf_seen;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pf_seen <= 1'b0;
		else if (start)
			pf_seen <= v_pf;
	end

	// renderer only takes a task when ready
	assert property (@(posedge clk) disable iff (!rst_n) tsr_go |-> tsr_rdy)
		else $error("tsr_go high while tsr_rdy low");

	// one walker at a time on the renderer port
	assert property (@(posedge clk) disable iff (!rst_n) !(tile_go && spr_go))
		else $error("tile_go and spr_go high together");

	// no DRAM traffic outside the prefetch window
	assert property (@(posedge clk) disable iff (!rst_n) dram_req |-> pf_seen)
		else $error("dram_req high without v_pf at the last start");

endmodule

`default_nettype wire

// File: tb_video_tsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_video_tsu import tsu_pkg::*; ();

	logic clk;
	logic rst_n;
	logic start;
	line_t line;
	logic v_ts;
	logic v_pf;
	page_t tsconf;
	page_t t0gpage;
	page_t t1gpage;
	page_t sgpage;
	page_t tmpage;
	logic [5:0] num_tiles;
	line_t t0x_offs;
	line_t t1x_offs;
	line_t t0y_offs;
	line_t t1y_offs;
	logic [1:0] t0_palsel;
	logic [1:0] t1_palsel;
	sf_addr_t sfile_addr;
	word_t sfile_data;
	logic sfile_we;
	dram_addr_t dram_addr;
	logic dram_req;
	logic dram_next = 1'b0;
	word_t dram_rdata = '0;
	logic tsr_go;
	tsr_addr_t tsr_addr;
	line_t tsr_line;
	page_t tsr_page;
	line_t tsr_x;
	xsize_t tsr_xs;
	logic tsr_xf;
	pal_t tsr_pal;
	logic tsr_rdy = 1'b0;

	// model state
	logic [31:0] rnd_state = 32'd33;
	logic [31:0] bus_state = 32'd33;
	word_t sf_model [SF_WORDS];
	word_t tmb_model [TMB_WORDS];
	dram_addr_t exp_dram [$];
	logic [39:0] exp_task [$];
	string test_name = "reset";

	video_tsu u_video_tsu (.*);

	bind video_tsu tsu_properties u_tsu_properties (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.v_pf     (v_pf),
		.dram_req (dram_req),
		.tsr_go   (tsr_go),
		.tsr_rdy  (tsr_rdy),
		.tile_go  (tile_go),
		.spr_go   (spr_go)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] next_rand();
		rnd_state = xorshift(rnd_state);
		return rnd_state;
	endfunction

	// DRAM content hashed from the full address with about a quarter zero tiles
	function automatic word_t dram_word(input dram_addr_t a);
		logic [31:0] s;
		word_t w;
		s = xorshift(xorshift({11'd0, a} ^ 32'h2545f491));
		w = s[15:0];
		if (s[18:17] == 2'd0)
			w[11:0] = 12'd0;
		return w;
	endfunction

	function automatic logic [39:0] pack_task(input line_t x, input line_t ln,
		input tsr_addr_t a, input page_t p, input xsize_t xs, input logic xf, input pal_t pal);
		return {x, ln, a, p, xs, xf, pal};
	endfunction

	task automatic abort_run(input string msg);
		$display("%s: %s", test_name, msg);
		$display("Test failures found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_dram_addr(input string name, input dram_addr_t exp,
		input dram_addr_t act);
		if (exp !== act)
		begin
			$display("** Error %s: dram_addr expected %h actual %h", name, exp, act);
			$display("Test failures found");
			$fatal(1, "dram address mismatch");
		end
	endtask

	task automatic check_task(input string name, input logic [39:0] exp, input line_t x,
		input line_t ln, input tsr_addr_t a, input page_t p, input xsize_t xs, input logic xf,
		input pal_t pal);
		logic [39:0] act;
		act = pack_task(x, ln, a, p, xs, xf, pal);
		if (exp !== act)
		begin
			$display("** Error %s: task {x,line,addr,page,xs,xf,pal} expected %h actual %h",
				name, exp, act);
			$display("Test failures found");
			$fatal(1, "task mismatch");
		end
	endtask

	// DRAM and renderer models share one random stream
	always @(posedge clk)
	begin
		bus_state = xorshift(bus_state);
		tsr_rdy <= bus_state[1:0] != 2'd0;
		// no back-to-back pulses so the address stays put for the write
		if (dram_req && !dram_next && bus_state[2])
		begin
			dram_next <= 1'b1;
			dram_rdata <= dram_word(dram_addr);
		end
		else
			dram_next <= 1'b0;
	end

	// monitor of the renderer and DRAM ports
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			if (tsr_go && !tsr_rdy)
				abort_run("tsr_go given while tsr_rdy was low");
			if (dram_req && !v_pf)
				abort_run("dram_req high outside the prefetch window");
			if (dram_next && dram_req)
			begin
				if (exp_dram.size() == 0)
					abort_run("DRAM read that the model does not expect");
				else
					check_dram_addr(test_name, exp_dram.pop_front(), dram_addr);
			end
			if (tsr_go)
			begin
				if (exp_task.size() == 0)
					abort_run("renderer task that the model does not expect");
				else
					check_task(test_name, exp_task.pop_front(), tsr_x, tsr_line, tsr_addr,
						tsr_page, tsr_xs, tsr_xf, tsr_pal);
			end
		end
	end

	// new sprite file with y near the tested lines
	task automatic write_sprites();
		word_t w;
		logic [31:0] r;
		for (int a = 0; a < SF_WORDS; a++)
		begin
			r = next_rand();
			w = r[15:0];
			if (a % 3 == 0)
			begin
				w[8:0] = line_t'(16 + (r[23:16] % 48));
				w[13] = r[25:24] != 2'd0;
				w[14] = r[30:26] == 5'd0;
			end
			sf_model[a] = w;
			@(posedge clk);
			sfile_addr <= sf_addr_t'(a);
			sfile_data <= w;
			sfile_we <= 1'b1;
		end
		@(posedge clk);
		sfile_we <= 1'b0;
	endtask

	// expected DRAM run and buffer update of the prefetch
	task automatic model_prefetch(input line_t ln);
		line_t tml;
		line_t yo;
		logic [5:0] row;
		logic plane;
		dram_addr_t a;
		tml = ln + line_t'(TM_LOOKAHEAD);
		for (int x = (tsconf[5] ? 0 : 8); x < (tsconf[6] ? 16 : 8); x++)
		begin
			plane = x[3];
			yo = plane ? t1y_offs : t0y_offs;
			row = tml[8:3] + yo[8:3];
			a = {tmpage, row, plane, tml[2:0], x[2:0]};
			exp_dram.push_back(a);
			tmb_model[{tml[4:3], tml[2:0], x[2:0], plane}] = dram_word(a);
		end
	endtask

	// sprite tasks of the three layers into q0, q1, q2
	task automatic model_sprites(input line_t ln, ref logic [39:0] q0 [$],
		ref logic [39:0] q1 [$], ref logic [39:0] q2 [$]);
		int idx;
		word_t r0;
		word_t r1;
		word_t r2;
		line_t dl;
		logic [5:0] ymax;
		logic [5:0] boff;
		logic [39:0] t;
		idx = 0;
		for (int b = 0; b <= 252 && idx < 3; b += 3)
		begin
			r0 = sf_model[b];
			r1 = sf_model[b + 1];
			r2 = sf_model[b + 2];
			dl = ln - r0[8:0];
			ymax = {r0[11:9], 3'b111};
			if (r0[13] && dl <= {3'b000, ymax})
			begin
				boff = r0[15] ? ymax - dl[5:0] : dl[5:0];
				t = pack_task(r1[8:0], {r2[11:6], 3'b000} + {3'b000, boff}, r2[5:0], sgpage,
					r1[11:9], r1[15], r2[15:12]);
				if (idx == 0)
					q0.push_back(t);
				else if (idx == 1)
					q1.push_back(t);
				else
					q2.push_back(t);
			end
			if (r0[14])
				idx++;
		end
	endtask

	// valid tiles of one plane from the model buffer
	task automatic model_tiles(input line_t ln, input int p);
		line_t xo;
		line_t tl;
		logic [5:0] col;
		word_t w;
		int cnt;
		cnt = (num_tiles == 6'd0) ? 64 : num_tiles;
		xo = p ? t1x_offs : t0x_offs;
		tl = ln + {6'd0, (p ? t1y_offs[2:0] : t0y_offs[2:0])};
		for (int k = 0; k < cnt; k++)
		begin
			col = 6'(k) + xo[8:3];
			w = tmb_model[{tl[4:3], col, p[0]}];
			if (w[11:0] != 12'd0 || tsconf[2 + p])
				exp_task.push_back(pack_task(line_t'(k * 8) - {6'd0, xo[2:0]},
					{w[11:6], tl[2:0] ^ {3{w[15]}}}, w[5:0], p ? t1gpage : t0gpage,
					3'd0, w[14], {p ? t1_palsel : t0_palsel, w[13:12]}));
		end
	endtask

	task automatic run_line(input line_t ln, input logic ts, input logic pf);
		logic [39:0] s0 [$];
		logic [39:0] s1 [$];
		logic [39:0] s2 [$];
		int cycles;
		test_name = $sformatf("line %0d", ln);
		if (pf && (tsconf[5] || tsconf[6]))
			model_prefetch(ln);
		if (ts && tsconf[7])
			model_sprites(ln, s0, s1, s2);
		exp_task = s0;
		if (ts && tsconf[5])
			model_tiles(ln, 0);
		exp_task = {exp_task, s1};
		if (ts && tsconf[6])
			model_tiles(ln, 1);
		exp_task = {exp_task, s2};
		@(posedge clk);
		start <= 1'b1;
		line <= ln;
		v_ts <= ts;
		v_pf <= pf;
		@(posedge clk);
		start <= 1'b0;
		@(posedge clk);
		cycles = 0;
		while (u_video_tsu.u_layer_sequencer.layer_skip !== '1)
		begin
			@(posedge clk);
			cycles++;
			if (cycles > 20000)
				abort_run("timed out waiting for the end of the line");
		end
		repeat (2)
			@(posedge clk);
		if (exp_task.size() != 0 || exp_dram.size() != 0)
			abort_run("line ended with expected tasks or DRAM reads missing");
	endtask

	initial
	begin
		logic [31:0] r;
		rst_n <= 1'b0;
		start <= 1'b0;
		line <= '0;
		v_ts <= 1'b0;
		v_pf <= 1'b0;
		tsconf <= 8'h60;
		t0gpage <= '0;
		t1gpage <= '0;
		sgpage <= '0;
		tmpage <= 8'h21;
		num_tiles <= '0;
		t0x_offs <= '0;
		t1x_offs <= '0;
		t0y_offs <= '0;
		t1y_offs <= '0;
		t0_palsel <= '0;
		t1_palsel <= '0;
		sfile_addr <= '0;
		sfile_data <= '0;
		sfile_we <= 1'b0;
		repeat (16)
			@(posedge clk);
		rst_n <= 1'b1;

		// idle outputs before the first start
		test_name = "idle after reset";
		for (int i = 0; i < 20; i++)
		begin
			@(posedge clk);
			if (tsr_go || dram_req)
				abort_run("tsr_go or dram_req high before the first start");
		end

		// fill every buffer slot with prefetch only lines
		for (int l = 0; l < 32; l++)
			run_line(line_t'(l), 1'b0, 1'b1);

		// random lines, config and sprites
		for (int l = 32; l < 64; l++)
		begin
			write_sprites();
			r = next_rand();
			tsconf <= r[7:0];
			num_tiles <= r[13:8];
			t0_palsel <= r[15:14];
			t1_palsel <= r[17:16];
			tmpage <= r[25:18];
			r = next_rand();
			t0x_offs <= r[8:0];
			t1x_offs <= r[17:9];
			t0y_offs <= r[26:18];
			r = next_rand();
			t1y_offs <= r[8:0];
			t0gpage <= r[16:9];
			t1gpage <= r[24:17];
			sgpage <= r[31:24];
			@(posedge clk);
			r = next_rand();
			run_line(line_t'(l), r[1:0] != 2'd0, r[4:2] != 3'd0);
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: video_tsu.f
tsu_pkg.sv
sprite_file.sv
tile_map_buffer.sv
tile_fetch.sv
tile_walker.sv
sprite_walker.sv
layer_sequencer.sv
video_tsu.sv
tsu_properties.sv
tb_video_tsu.sv
